// File: vlog.f
+incdir+include
src/exu_pkg.sv
src/ex_stage_reg.sv
src/operand_forward.sv
src/alu.sv
src/branch_unit.sv
src/shift_add_mul.sv
src/exu_top.sv
test/exu_chk.sv
test/tb_exu.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_exu \
    --Mdir obj_dir -o sim_exu \
    && ./obj_dir/sim_exu +verilator+error+limit+1000 2>&1 | tee sim.log \
    || { echo "build or run failed"; exit 1; }

grep -qF '*** PASSED ***' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: test/tb_exu.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module tb_exu;

    logic              clk;
    logic              rst_n;
    exu_pkg::id_ex_t   id_ex;
    logic              in_ready;
    exu_pkg::fwd_src_t mem_fwd;
    exu_pkg::fwd_src_t wb_fwd;
    logic              branch_flush;
    exu_pkg::ex_mem_t  ex_mem;
    logic              out_ready;
    exu_pkg::xword_t   dnpc;
    logic              pc_update;

    int seed = 60144;
    int test_err;
    int total_err;
    int tests_run;

    exu_top exu_top_inst (.*);

    bind exu_top exu_chk exu_chk_inst (
        .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .in_ready(in_ready),
        .mem_fwd(mem_fwd), .wb_fwd(wb_fwd), .branch_flush(branch_flush),
        .ex_mem(ex_mem), .out_ready(out_ready), .dnpc(dnpc), .pc_update(pc_update)
    );

    always #4 clk = ~clk;  // 8 ns period

    function automatic exu_pkg::xword_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // reference alu from the rv64 integer rules
    function automatic exu_pkg::xword_t alu_expect(input exu_pkg::ex_op_t op,
        input exu_pkg::xword_t pc, input exu_pkg::xword_t a, input exu_pkg::xword_t b);
        case (op)
            exu_pkg::op_add:   return a + b;
            exu_pkg::op_sub:   return a - b;
            exu_pkg::op_sll:   return a << b[5:0];
            exu_pkg::op_slt:   return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            exu_pkg::op_sltu:  return (a < b) ? 64'd1 : 64'd0;
            exu_pkg::op_xor:   return a ^ b;
            exu_pkg::op_srl:   return a >> b[5:0];
            exu_pkg::op_sra:   return $signed(a) >>> b[5:0];
            exu_pkg::op_or:    return a | b;
            exu_pkg::op_and:   return a & b;
            exu_pkg::op_lui:   return b;
            exu_pkg::op_auipc: return pc + b;
            default:           return pc + 64'd4;
        endcase
    endfunction

    function automatic logic cond_taken(input exu_pkg::ex_op_t op,
        input exu_pkg::xword_t a, input exu_pkg::xword_t b);
        case (op)
            exu_pkg::op_beq:  return a == b;
            exu_pkg::op_bne:  return a != b;
            exu_pkg::op_blt:  return $signed(a) < $signed(b);
            exu_pkg::op_bge:  return $signed(a) >= $signed(b);
            exu_pkg::op_bltu: return a < b;
            exu_pkg::op_bgeu: return a >= b;
            default:          return 1'b1;
        endcase
    endfunction

    function automatic exu_pkg::id_ex_t make_ins(input exu_pkg::ex_op_t op,
        input logic use_imm, input exu_pkg::xword_t pc, input exu_pkg::xword_t a,
        input exu_pkg::xword_t b, input exu_pkg::xword_t imm);
        exu_pkg::id_ex_t ins;
        ins = '0;
        ins.valid   = 1'b1;
        ins.pc      = pc;
        ins.op      = op;
        ins.use_imm = use_imm;
        ins.rd      = 5'd5;
        ins.rs1     = 5'd3;
        ins.rs2     = 5'd4;
        ins.src_a   = a;
        ins.src_b   = b;
        ins.imm     = imm;
        return ins;
    endfunction

    task automatic check_val(input string name, input exu_pkg::xword_t exp,
        input exu_pkg::xword_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            test_err++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-8s %s (%0d errors)", name, (test_err == 0) ? "ok" : "failed", test_err);
        total_err += test_err;
        tests_run++;
        test_err = 0;
    endtask

    // called 1 ns after an edge; returns 1 ns after the accepting edge
    task automatic issue(input exu_pkg::id_ex_t ins);
        int n;
        n = 0;
        id_ex = ins;
        @(negedge clk);
        while (!in_ready && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            $display("stage never became ready to accept an instruction");
            test_err++;
        end
        @(posedge clk);
        #1;
        id_ex = '0;
    endtask

    task automatic fwd_case(input string name, input logic mv, input logic [4:0] mrd,
        input logic wv, input logic [4:0] wrd, input logic [4:0] rs1,
        input exu_pkg::xword_t exp_a, input exu_pkg::xword_t exp_b);
        exu_pkg::id_ex_t ins;
        ins = make_ins(exu_pkg::op_add, 1'b0, 64'h100, 64'd100, 64'd200, 64'd0);
        ins.rs1 = rs1;
        mem_fwd = '{valid: mv, rd: mrd, data: 64'h1100};
        wb_fwd  = '{valid: wv, rd: wrd, data: 64'h2200};
        issue(ins);
        @(negedge clk);
        check_val({name, " result"}, exp_a + exp_b, ex_mem.result);
        check_val({name, " store_data"}, exp_b, ex_mem.store_data);
        @(posedge clk);
        #1;
        mem_fwd = '0;
        wb_fwd  = '0;
    endtask

    initial begin
        exu_pkg::ex_op_t op;
        exu_pkg::xword_t a;
        exu_pkg::xword_t b;
        exu_pkg::xword_t imm;
        exu_pkg::xword_t pc;
        logic            tk;
        int              n;
        clk = 0;
        rst_n = 0;
        id_ex = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        branch_flush = 0;
        out_ready = 1;
        test_err = 0;
        total_err = 0;
        tests_run = 0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1;

        for (int i = 0; i < 12; i++) begin  // add .. auipc
            for (int k = 0; k < 8; k++) begin
                op = exu_pkg::ex_op_t'(5'(i));
                a = rand64();
                b = rand64();
                imm = rand64();
                pc = rand64();
                issue(make_ins(op, k[0], pc, a, b, imm));
                @(negedge clk);
                check_val(op.name(), alu_expect(op, pc, a, k[0] ? imm : b), ex_mem.result);
                check_val({op.name(), " pc"}, pc, ex_mem.pc);
                check_val({op.name(), " rd"}, 64'd5, 64'(ex_mem.rd));
                @(posedge clk);
                #1;
            end
        end
        finish_test("alu");

        fwd_case("fwd both", 1, 3, 1, 3, 3, 64'h1100, 64'd200);
        fwd_case("fwd wb", 0, 4, 1, 4, 3, 64'd100, 64'h2200);
        fwd_case("fwd none", 1, 7, 1, 8, 3, 64'd100, 64'd200);
        fwd_case("fwd x0", 1, 0, 1, 0, 0, 64'd100, 64'd200);
        finish_test("forward");

        for (int i = 12; i < 20; i++) begin  // beq .. jalr
            for (int k = 0; k < 3; k++) begin
                op = exu_pkg::ex_op_t'(5'(i));
                a = (k == 2) ? -64'sd3 : 64'd5;
                b = (k == 1) ? 64'd7 : ((k == 2) ? 64'd2 : 64'd5);
                pc = 64'h1000;
                tk = cond_taken(op, a, b);
                issue(make_ins(op, 1'b0, pc, a, b, 64'h40));
                @(negedge clk);
                check_val({op.name(), " dnpc"},
                    tk ? ((op == exu_pkg::op_jalr) ? a : pc) + 64'h40 : pc + 64'd4, dnpc);
                check_val({op.name(), " pc_update"}, 64'(tk), 64'(pc_update));
                if (i >= 18) check_val({op.name(), " link"}, pc + 64'd4, ex_mem.result);
                @(posedge clk);
                #1;
            end
        end
        issue(make_ins(exu_pkg::op_beq, 1'b0, 64'h2000, 64'd1, 64'd1, 64'h80));
        out_ready = 0;
        @(negedge clk);
        check_val("beq held pc_update", 64'd0, 64'(pc_update));
        @(posedge clk);
        #1 out_ready = 1;
        @(negedge clk);
        check_val("beq released pc_update", 64'd1, 64'(pc_update));
        @(posedge clk);
        #1;
        finish_test("branch");

        for (int k = 0; k < 3; k++) begin
            a = rand64();
            b = rand64();
            issue(make_ins(exu_pkg::op_mul, 1'b0, 64'h3000, a, b, 64'd0));
            out_ready = 0;  // keep the product in place once it arrives
            n = 0;
            @(negedge clk);
            while (!ex_mem.valid && n < `EXU_MUL_STEPS + 4) begin
                check_val("mul in_ready", 64'd0, 64'(in_ready));
                @(negedge clk);
                n++;
            end
            if (!ex_mem.valid) begin
                $display("multiply product never became valid");
                test_err++;
            end
            repeat (3) begin
                check_val("mul product", a * b, ex_mem.result);
                check_val("mul held valid", 64'd1, 64'(ex_mem.valid));
                @(negedge clk);
            end
            @(posedge clk);
            #1 out_ready = 1;
            @(posedge clk);
            #1;
        end
        finish_test("mul");

        issue(make_ins(exu_pkg::op_jal, 1'b0, 64'h4000, 64'd0, 64'd0, 64'h10));
        rst_n = 0;
        @(posedge clk);
        #1;
        repeat (2) begin
            @(negedge clk);
            check_val("reset valid", 64'd0, 64'(ex_mem.valid));
            check_val("reset pc_update", 64'd0, 64'(pc_update));
        end
        @(posedge clk);
        #1 rst_n = 1;
        issue(make_ins(exu_pkg::op_add, 1'b0, 64'h5000, 64'd1, 64'd2, 64'd0));
        branch_flush = 1;
        @(posedge clk);
        #1 branch_flush = 0;
        @(negedge clk);
        check_val("flush valid", 64'd0, 64'(ex_mem.valid));
        @(posedge clk);
        #1;
        issue(make_ins(exu_pkg::op_mul, 1'b0, 64'h5100, 64'd9, 64'd9, 64'd0));
        repeat (10) @(posedge clk);
        #1 branch_flush = 1;
        @(posedge clk);
        #1 branch_flush = 0;
        @(negedge clk);
        check_val("flush mul valid", 64'd0, 64'(ex_mem.valid));
        check_val("flush mul in_ready", 64'(out_ready), 64'(in_ready));
        @(posedge clk);
        #1;
        finish_test("flush");

        repeat (2) @(posedge clk);
        $display("tests %0d, check errors %0d, assertion failures %0d",
            tests_run, total_err, exu_top_inst.exu_chk_inst.fail_cnt);
        if (total_err == 0 && exu_top_inst.exu_chk_inst.fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/exu_chk.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_chk (
    input logic              clk,
    input logic              rst_n,
    input exu_pkg::id_ex_t   id_ex,
    input logic              in_ready,
    input exu_pkg::fwd_src_t mem_fwd,
    input exu_pkg::fwd_src_t wb_fwd,
    input logic              branch_flush,
    input exu_pkg::ex_mem_t  ex_mem,
    input logic              out_ready,
    input exu_pkg::xword_t   dnpc,
    input logic              pc_update
);

    int              fail_cnt = 0;
    logic [7:0]      mul_wait;  // cycles since a mul was accepted
    exu_pkg::xword_t exp_prod;
    logic            mul_accept;
    exu_pkg::id_ex_t cur;       // instruction held in execute

    // operand as seen by the stage with mem before wb and x0 never forwarded
    function automatic exu_pkg::xword_t seen_value(
        input exu_pkg::reg_idx_t idx,
        input exu_pkg::xword_t   rf_val
    );
        if (idx == 0) return rf_val;
        if (mem_fwd.valid && mem_fwd.rd == idx) return mem_fwd.data;
        if (wb_fwd.valid && wb_fwd.rd == idx) return wb_fwd.data;
        return rf_val;
    endfunction

    assign mul_accept = rst_n && !branch_flush && in_ready && id_ex.valid
                        && (id_ex.op == exu_pkg::op_mul);

    always_ff @(posedge clk) begin
        if (!rst_n || branch_flush) begin
            mul_wait <= '0;
        end else if (mul_accept) begin
            mul_wait <= 8'd1;
            exp_prod <= seen_value(id_ex.rs1, id_ex.src_a) * seen_value(id_ex.rs2, id_ex.src_b);
        end else if (mul_wait == 8'(`EXU_MUL_STEPS + 2)) begin
            mul_wait <= '0;
        end else if (mul_wait != 0) begin
            mul_wait <= mul_wait + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || branch_flush) begin
            cur <= '0;
        end else if (in_ready) begin
            cur <= id_ex;
        end
    end

    a_reset: assert property (@(posedge clk) !rst_n |=> !ex_mem.valid && !pc_update)
        else begin
            $error("output valid or redirect after reset");
            fail_cnt++;
        end

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        branch_flush |=> !ex_mem.valid)
        else begin
            $error("result still valid after flush");
            fail_cnt++;
        end

    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (mul_wait == 0 || mul_wait > 8'(`EXU_MUL_STEPS + 1)) |-> in_ready == out_ready)
        else begin
            $error("in_ready differs from out_ready outside a multiply");
            fail_cnt++;
        end

    a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        pc_update |-> out_ready && cur.valid
                      && cur.op >= exu_pkg::op_beq && cur.op <= exu_pkg::op_jalr)
        else begin
            $error("pc_update without a valid branch or jump and out_ready");
            fail_cnt++;
        end

    a_jal: assert property (@(posedge clk) disable iff (!rst_n)
        cur.valid && out_ready && (cur.op == exu_pkg::op_jal)
        |-> pc_update && dnpc == cur.pc + cur.imm)
        else begin
            $error("jal did not redirect to pc plus imm");
            fail_cnt++;
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ex_mem.valid && !out_ready && !branch_flush |=> ex_mem.valid && $stable(ex_mem.result))
        else begin
            $error("result not held under back-pressure");
            fail_cnt++;
        end

    a_mul_wait: assert property (@(posedge clk) disable iff (!rst_n || branch_flush)
        (mul_wait != 0 && mul_wait <= 8'(`EXU_MUL_STEPS + 1)) |-> !ex_mem.valid && !in_ready)
        else begin
            $error("stage not blocked during multiply");
            fail_cnt++;
        end

    a_mul_done: assert property (@(posedge clk) disable iff (!rst_n || branch_flush)
        mul_wait == 8'(`EXU_MUL_STEPS + 2) |-> ex_mem.valid && ex_mem.result == exp_prod)
        else begin
            $error("product late or wrong");
            fail_cnt++;
        end

endmodule

// File: src/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  exu_pkg::id_ex_t   id_ex,
    output logic              in_ready,
    input  exu_pkg::fwd_src_t mem_fwd,
    input  exu_pkg::fwd_src_t wb_fwd,
    input  logic              branch_flush,
    output exu_pkg::ex_mem_t  ex_mem,
    input  logic              out_ready,
    output exu_pkg::xword_t   dnpc,
    output logic              pc_update
);

    exu_pkg::id_ex_t ex_q;
    exu_pkg::xword_t op_a;
    exu_pkg::xword_t op_b;
    exu_pkg::xword_t alu_result;
    exu_pkg::xword_t product;
    logic            is_mul;
    logic            mul_busy;
    logic            mul_done;
    logic            mul_block;
    logic            mul_start;

    assign is_mul    = ex_q.valid && (ex_q.op == exu_pkg::op_mul);
    assign mul_block = is_mul && !mul_done;  // waiting on the product
    assign mul_start = is_mul && !mul_busy && !mul_done;
    assign in_ready  = mul_block ? 1'b0 : out_ready;

    ex_stage_reg ex_stage_reg_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (in_ready),
        .flush (branch_flush),
        .d     (id_ex),
        .q     (ex_q)
    );

    operand_forward operand_forward_inst (
        .rs1     (ex_q.rs1),
        .rs2     (ex_q.rs2),
        .src_a   (ex_q.src_a),
        .src_b   (ex_q.src_b),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .op_a    (op_a),
        .op_b    (op_b)
    );

    alu alu_inst (
        .op      (ex_q.op),
        .use_imm (ex_q.use_imm),
        .pc      (ex_q.pc),
        .rs1_val (op_a),
        .rs2_val (op_b),
        .imm     (ex_q.imm),
        .result  (alu_result)
    );

    branch_unit branch_unit_inst (
        .valid     (ex_q.valid),
        .op        (ex_q.op),
        .pc        (ex_q.pc),
        .rs1_val   (op_a),
        .rs2_val   (op_b),
        .imm       (ex_q.imm),
        .out_ready (out_ready),
        .dnpc      (dnpc),
        .pc_update (pc_update)
    );

    // consumed on the edge where the register takes the next instruction
    shift_add_mul shift_add_mul_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (mul_start),
        .flush        (branch_flush),
        .consume      (in_ready),
        .multiplicand (op_a),
        .multiplier   (op_b),
        .busy         (mul_busy),
        .done         (mul_done),
        .product      (product)
    );

    always_comb begin
        ex_mem.valid      = ex_q.valid && !mul_block;
        ex_mem.pc         = ex_q.pc;
        ex_mem.rd         = ex_q.rd;
        ex_mem.result     = is_mul ? product : alu_result;
        ex_mem.store_data = op_b;  // forwarded rs2
    end

endmodule

// File: src/shift_add_mul.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module shift_add_mul (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            flush,
    input  logic            consume,
    input  exu_pkg::xword_t multiplicand,
    input  exu_pkg::xword_t multiplier,
    output logic            busy,
    output logic            done,
    output exu_pkg::xword_t product
);

    exu_pkg::mul_state_t state;
    exu_pkg::mul_cnt_t   cnt;
    exu_pkg::xword_t     acc;
    exu_pkg::xword_t     mcand;   // shifted left each step
    exu_pkg::xword_t     mplier;  // shifted right each step
    logic                launch;
    logic                last_step;

    // a start is ignored while a product is being built
    assign launch    = start && (state != exu_pkg::mul_run);
    assign last_step = (cnt == exu_pkg::mul_cnt_t'(`EXU_MUL_STEPS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            state <= exu_pkg::mul_idle;
        end else begin
            case (state)
                exu_pkg::mul_idle: begin
                    if (launch) state <= exu_pkg::mul_run;
                end
                exu_pkg::mul_run: begin
                    if (last_step) state <= exu_pkg::mul_done;
                end
                exu_pkg::mul_done: begin
                    if (launch) begin
                        state <= exu_pkg::mul_run;
                    end else if (consume) begin
                        state <= exu_pkg::mul_idle;
                    end
                end
                default: state <= exu_pkg::mul_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            acc    <= '0;
            mcand  <= multiplicand;
            mplier <= multiplier;
            cnt    <= '0;
        end else if (state == exu_pkg::mul_run) begin
            if (mplier[0]) acc <= acc + mcand;  // bits past 63 drop out
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            cnt    <= cnt + 1'b1;
        end
    end

    assign busy    = (state == exu_pkg::mul_run);
    assign done    = (state == exu_pkg::mul_done);
    assign product = acc;

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module branch_unit (
    input  logic            valid,
    input  exu_pkg::ex_op_t op,
    input  exu_pkg::xword_t pc,
    input  exu_pkg::xword_t rs1_val,
    input  exu_pkg::xword_t rs2_val,
    input  exu_pkg::xword_t imm,
    input  logic            out_ready,
    output exu_pkg::xword_t dnpc,
    output logic            pc_update
);

    logic            taken;
    exu_pkg::xword_t target;
    exu_pkg::xword_t seq_pc;

    always_comb begin
        case (op)
            exu_pkg::op_beq:  taken = (rs1_val == rs2_val);
            exu_pkg::op_bne:  taken = (rs1_val != rs2_val);
            exu_pkg::op_blt:  taken = ($signed(rs1_val) < $signed(rs2_val));
            exu_pkg::op_bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            exu_pkg::op_bltu: taken = (rs1_val < rs2_val);
            exu_pkg::op_bgeu: taken = (rs1_val >= rs2_val);
            exu_pkg::op_jal,
            exu_pkg::op_jalr: taken = 1'b1;  // jumps always redirect
            default:          taken = 1'b0;
        endcase
    end

    // jalr is register relative, the rest pc relative
    assign target = (op == exu_pkg::op_jalr) ? rs1_val + imm : pc + imm;
    assign seq_pc = pc + exu_pkg::xword_t'(`EXU_INST_STEP);
    assign dnpc   = taken ? target : seq_pc;

    // repeats while held, fetch takes it on the out_ready cycle
    assign pc_update = valid && out_ready && taken;

endmodule

// File: src/alu.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module alu (
    input  exu_pkg::ex_op_t op,
    input  logic            use_imm,
    input  exu_pkg::xword_t pc,
    input  exu_pkg::xword_t rs1_val,
    input  exu_pkg::xword_t rs2_val,
    input  exu_pkg::xword_t imm,
    output exu_pkg::xword_t result
);

    exu_pkg::xword_t opnd_a;
    exu_pkg::xword_t opnd_b;
    logic [5:0]      shamt;

    always_comb begin
        case (op)
            exu_pkg::op_auipc: opnd_a = pc;
            exu_pkg::op_lui:   opnd_a = '0;  // lui is 0 + imm
            default:           opnd_a = rs1_val;
        endcase
    end

    assign opnd_b = use_imm ? imm : rs2_val;
    assign shamt  = opnd_b[5:0];  // rv64 shift range

    always_comb begin
        case (op)
            exu_pkg::op_sub:  result = opnd_a - opnd_b;
            exu_pkg::op_sll:  result = opnd_a << shamt;
            exu_pkg::op_slt:  result = exu_pkg::xword_t'($signed(opnd_a) < $signed(opnd_b));
            exu_pkg::op_sltu: result = exu_pkg::xword_t'(opnd_a < opnd_b);
            exu_pkg::op_xor:  result = opnd_a ^ opnd_b;
            exu_pkg::op_srl:  result = opnd_a >> shamt;
            exu_pkg::op_sra:  result = exu_pkg::xword_t'($signed(opnd_a) >>> shamt);
            exu_pkg::op_or:   result = opnd_a | opnd_b;
            exu_pkg::op_and:  result = opnd_a & opnd_b;
            // link value for rd
            exu_pkg::op_jal,
            exu_pkg::op_jalr: result = pc + exu_pkg::xword_t'(`EXU_INST_STEP);
            // add, lui, auipc; branches and mul ignore it
            default:          result = opnd_a + opnd_b;
        endcase
    end

endmodule

// File: src/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  exu_pkg::reg_idx_t rs1,
    input  exu_pkg::reg_idx_t rs2,
    input  exu_pkg::xword_t   src_a,
    input  exu_pkg::xword_t   src_b,
    input  exu_pkg::fwd_src_t mem_fwd,
    input  exu_pkg::fwd_src_t wb_fwd,
    output exu_pkg::xword_t   op_a,
    output exu_pkg::xword_t   op_b
);

    // mem is younger than wb, so it wins on a double hit
    function automatic exu_pkg::xword_t pick(
        input exu_pkg::reg_idx_t idx,
        input exu_pkg::xword_t   rf_val,
        input exu_pkg::fwd_src_t mem,
        input exu_pkg::fwd_src_t wb
    );
        exu_pkg::xword_t val;
        val = rf_val;
        if (idx != '0) begin  // x0 reads as the rf value
            if (mem.valid && (mem.rd == idx)) begin
                val = mem.data;
            end else if (wb.valid && (wb.rd == idx)) begin
                val = wb.data;
            end
        end
        return val;
    endfunction

    assign op_a = pick(rs1, src_a, mem_fwd, wb_fwd);
    assign op_b = pick(rs2, src_b, mem_fwd, wb_fwd);

endmodule

// File: src/ex_stage_reg.sv
`timescale 1ns/1ps

module ex_stage_reg (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  logic            flush,
    input  exu_pkg::id_ex_t d,
    output exu_pkg::id_ex_t q
);

    exu_pkg::id_ex_t ex_reg;

    // flush beats load, otherwise hold while stalled
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ex_reg <= '0;
        end else if (load) begin
            ex_reg <= d;
        end
    end

    assign q = ex_reg;

endmodule

// File: src/exu_pkg.sv
`include "exu_consts.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0] xword_t;
    typedef logic [`EXU_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [$clog2(`EXU_MUL_STEPS+1)-1:0] mul_cnt_t;  // 0 .. steps

    // operation code delivered by decode
    typedef enum logic [4:0] {
        op_add, op_sub, op_sll, op_slt, op_sltu,      // integer alu
        op_xor, op_srl, op_sra, op_or, op_and,
        op_lui, op_auipc,                             // upper immediates
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_jal, op_jalr,
        op_mul
    } ex_op_t;

    typedef enum logic [1:0] {
        mul_idle,
        mul_run,
        mul_done
    } mul_state_t;

    // decode to execute
    typedef struct packed {
        logic     valid;
        xword_t   pc;
        ex_op_t   op;
        logic     use_imm;  // imm replaces rs2 value as alu operand b
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;      // zero when the instruction has no rs2
        xword_t   src_a;
        xword_t   src_b;
        xword_t   imm;
    } id_ex_t;

    // valid means this stage will write data to rd
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xword_t   data;
    } fwd_src_t;

    typedef struct packed {
        logic     valid;
        xword_t   pc;
        reg_idx_t rd;
        xword_t   result;
        xword_t   store_data;
    } ex_mem_t;

endpackage

// File: include/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// datapath and address width
`define EXU_XLEN 64

// register file has 32 entries
`define EXU_REG_IDX_W 5

// sequential pc step, 32-bit instructions only
`define EXU_INST_STEP 4

// one multiplier bit per cycle
`define EXU_MUL_STEPS 64

`endif
